/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_biquad8_pole_fir
RTL_TOP    ?= biquad8_pole_fir
FILELIST   ?= verilog.f
OBJ_DIR    ?= obj_dir
JOBS       ?= 4
VFLAGS     ?= --binary --timing -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Pass only when the simulation prints the pass line
run: build
	@out="$$($(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/biquad8_pole_fir.sv */
`timescale 1ns/1ns
`include "pole_fir_cfg.svh"

module biquad8_pole_fir (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  pole_fir_pkg::sample_vec_t   dat_i,
    input  pole_fir_pkg::coeff_sel_t    coeff_adr_i,
    input  logic                        coeff_wr_i,
    input  logic                        coeff_update_i,
    input  pole_fir_pkg::coeff_t        coeff_dat_i,
    output pole_fir_pkg::acc_t          y0_o,
    output pole_fir_pkg::acc_t          y1_o
);

    // Active coefficients
    pole_fir_pkg::coeff_t [`PF_F_TAPS:0] f_coeff;
    pole_fir_pkg::coeff_t [`PF_G_TAPS:0] g_coeff;
    pole_fir_pkg::coeff_t fx_coeff;
    pole_fir_pkg::coeff_t gx_coeff;

    // Staggered samples for each chain
    pole_fir_pkg::sample_t [`PF_F_TAPS-1:0] f_tap;
    pole_fir_pkg::sample_t [`PF_G_TAPS-1:0] g_tap;

    // Chain results
    pole_fir_pkg::acc_t f_sum;
    pole_fir_pkg::acc_t g_sum;
    pole_fir_pkg::acc_t f_filt;
    pole_fir_pkg::acc_t g_filt;

    pole_coeff_regs u_coeff_regs (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .coeff_adr_i    (coeff_adr_i),
        .coeff_wr_i     (coeff_wr_i),
        .coeff_update_i (coeff_update_i),
        .coeff_dat_i    (coeff_dat_i),
        .f_coeff_o      (f_coeff),
        .g_coeff_o      (g_coeff),
        .fx_coeff_o     (fx_coeff),
        .gx_coeff_o     (gx_coeff)
    );

    sample_skew u_skew (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dat_i   (dat_i),
        .f_tap_o (f_tap),
        .g_tap_o (g_tap)
    );

    // f chain is one tap shorter, so it gets one alignment register
    pole_fir_chain #(
        .NTAPS (`PF_F_TAPS),
        .ALIGN (1)
    ) u_f_chain (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .unity_i (dat_i[0]),
        .tap_i   (f_tap),
        .coeff_i (f_coeff),
        .sum_o   (f_sum),
        .filt_o  (f_filt)
    );

    pole_fir_chain #(
        .NTAPS (`PF_G_TAPS),
        .ALIGN (0)
    ) u_g_chain (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .unity_i (dat_i[1]),
        .tap_i   (g_tap),
        .coeff_i (g_coeff),
        .sum_o   (g_sum),
        .filt_o  (g_filt)
    );

    pole_cross_link u_cross (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .f_sum_i    (f_sum),
        .g_sum_i    (g_sum),
        .f_filt_i   (f_filt),
        .g_filt_i   (g_filt),
        .fx_coeff_i (fx_coeff),
        .gx_coeff_i (gx_coeff),
        .y0_o       (y0_o),
        .y1_o       (y1_o)
    );

endmodule

/* design/pole_coeff_regs.sv */
`timescale 1ns/1ns
`include "pole_fir_cfg.svh"

module pole_coeff_regs (
    input  logic                                    clk,
    input  logic                                    rst_n_i,
    input  pole_fir_pkg::coeff_sel_t                coeff_adr_i,
    input  logic                                    coeff_wr_i,
    input  logic                                    coeff_update_i,
    input  pole_fir_pkg::coeff_t                    coeff_dat_i,
    output pole_fir_pkg::coeff_t [`PF_F_TAPS:0]     f_coeff_o,
    output pole_fir_pkg::coeff_t [`PF_G_TAPS:0]     g_coeff_o,
    output pole_fir_pkg::coeff_t                    fx_coeff_o,
    output pole_fir_pkg::coeff_t                    gx_coeff_o
);

    // Strobes and data one cycle after the port
    pole_fir_pkg::coeff_wr_t wr_q;

    // Shadow banks take writes, active banks drive the arithmetic
    // Position 0 is tap 0, the top position is the tail coefficient
    pole_fir_pkg::coeff_t [`PF_F_TAPS:0] f_shadow_q;
    pole_fir_pkg::coeff_t [`PF_F_TAPS:0] f_active_q;
    pole_fir_pkg::coeff_t [`PF_G_TAPS:0] g_shadow_q;
    pole_fir_pkg::coeff_t [`PF_G_TAPS:0] g_active_q;
    pole_fir_pkg::coeff_t fx_shadow_q;
    pole_fir_pkg::coeff_t fx_active_q;
    pole_fir_pkg::coeff_t gx_shadow_q;
    pole_fir_pkg::coeff_t gx_active_q;

    // Address decode, registered once
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_q <= '0;
        end else begin
            wr_q.f_wr   <= coeff_wr_i && (coeff_adr_i == `PF_SEL_F);
            wr_q.g_wr   <= coeff_wr_i && (coeff_adr_i == `PF_SEL_G);
            wr_q.fx_wr  <= coeff_wr_i && (coeff_adr_i == `PF_SEL_FX);
            wr_q.gx_wr  <= coeff_wr_i && (coeff_adr_i == `PF_SEL_GX);
            wr_q.update <= coeff_update_i;
            wr_q.data   <= coeff_dat_i;
        end
    end

    // Shadow cascade: new word lands in position 0, older words move toward the tail
    // Update copies every shadow into its active register on the same edge
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            f_shadow_q  <= '0;
            g_shadow_q  <= '0;
            fx_shadow_q <= '0;
            gx_shadow_q <= '0;
            f_active_q  <= '0;
            g_active_q  <= '0;
            fx_active_q <= '0;
            gx_active_q <= '0;
        end else begin
            if (wr_q.f_wr) begin
                f_shadow_q <= {f_shadow_q[`PF_F_TAPS-1:0], wr_q.data};
            end
            if (wr_q.g_wr) begin
                g_shadow_q <= {g_shadow_q[`PF_G_TAPS-1:0], wr_q.data};
            end
            if (wr_q.fx_wr) begin
                fx_shadow_q <= wr_q.data;
            end
            if (wr_q.gx_wr) begin
                gx_shadow_q <= wr_q.data;
            end
            // Active set sees the shadows as they were before this edge
            if (wr_q.update) begin
                f_active_q  <= f_shadow_q;
                g_active_q  <= g_shadow_q;
                fx_active_q <= fx_shadow_q;
                gx_active_q <= gx_shadow_q;
            end
        end
    end

    assign f_coeff_o  = f_active_q;
    assign g_coeff_o  = g_active_q;
    assign fx_coeff_o = fx_active_q;
    assign gx_coeff_o = gx_active_q;

endmodule

/* design/pole_cross_link.sv */
`timescale 1ns/1ns
`include "pole_fir_cfg.svh"

module pole_cross_link (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  pole_fir_pkg::acc_t    f_sum_i,
    input  pole_fir_pkg::acc_t    g_sum_i,
    input  pole_fir_pkg::acc_t    f_filt_i,
    input  pole_fir_pkg::acc_t    g_filt_i,
    input  pole_fir_pkg::coeff_t  fx_coeff_i,
    input  pole_fir_pkg::coeff_t  gx_coeff_i,
    output pole_fir_pkg::acc_t    y0_o,
    output pole_fir_pkg::acc_t    y1_o
);

    // Chain sums held one more cycle so they line up with F and G
    pole_fir_pkg::acc_t f_sum_q;
    pole_fir_pkg::acc_t g_sum_q;

    // Truncated previous sums of the opposite chain
    pole_fir_pkg::arg_t f_arg;
    pole_fir_pkg::arg_t g_arg;

    pole_fir_pkg::acc_t y0_q;
    pole_fir_pkg::acc_t y1_q;

    assign f_arg = f_sum_q[`PF_COEFF_FRAC +: `PF_ARG_W];
    assign g_arg = g_sum_q[`PF_COEFF_FRAC +: `PF_ARG_W];

    // y0 takes g from the other chain, y1 takes f
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            f_sum_q <= '0;
            g_sum_q <= '0;
            y0_q    <= '0;
            y1_q    <= '0;
        end else begin
            f_sum_q <= f_sum_i;
            g_sum_q <= g_sum_i;
            y0_q    <= f_filt_i + fx_coeff_i * g_arg;
            y1_q    <= g_filt_i + gx_coeff_i * f_arg;
        end
    end

    assign y0_o = y0_q;
    assign y1_o = y1_q;

endmodule

/* design/pole_fir_cfg.svh */
`ifndef POLE_FIR_CFG_SVH
`define POLE_FIR_CFG_SVH

// Samples arriving on dat_i every clock
`define PF_NSAMP 8

// Signed sample width
`define PF_SAMP_W 16

// Signed coefficient width, same as a DSP B port
`define PF_COEFF_W 18

// Accumulator and output width, wraps like a P register
`define PF_ACC_W 48

// Truncated previous sum that feeds a multiplier, A port sized
`define PF_ARG_W 30

// Coefficient fraction bits
// Unity term moves up by this, previous sums move down by it
`define PF_COEFF_FRAC 14

// Tap counts of the two compensating FIRs
`define PF_F_TAPS 6
`define PF_G_TAPS 7

// Bank selector codes on coeff_adr_i
`define PF_SEL_F 2'd0
`define PF_SEL_G 2'd1
`define PF_SEL_FX 2'd2
`define PF_SEL_GX 2'd3

`endif

/* design/pole_fir_chain.sv */
`timescale 1ns/1ns
`include "pole_fir_cfg.svh"

module pole_fir_chain #(
    parameter int NTAPS = 6,
    parameter int ALIGN = 0
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  pole_fir_pkg::sample_t               unity_i,
    input  pole_fir_pkg::sample_t [NTAPS-1:0]   tap_i,
    input  pole_fir_pkg::coeff_t  [NTAPS:0]     coeff_i,
    output pole_fir_pkg::acc_t                  sum_o,
    output pole_fir_pkg::acc_t                  filt_o
);

    // Unity coefficient term, sample scaled up to the coefficient format
    pole_fir_pkg::acc_t unity_term;

    // One product per tap, wraps at accumulator width
    pole_fir_pkg::acc_t [NTAPS-1:0] prod;

    // Systolic partial sums, one register per tap
    pole_fir_pkg::acc_t [NTAPS-1:0] stage_q;

    // Chain sum after any alignment registers
    pole_fir_pkg::acc_t chain_sum;

    // Tail stage state
    pole_fir_pkg::acc_t prev_q;
    pole_fir_pkg::arg_t prev_arg;
    pole_fir_pkg::acc_t tail_prod;
    pole_fir_pkg::acc_t filt_q;

    assign unity_term = pole_fir_pkg::acc_t'(unity_i) <<< `PF_COEFF_FRAC;

    always_comb begin
        for (int j = 0; j < NTAPS; j++) begin
            prod[j] = coeff_i[j] * tap_i[j];
        end
    end

    // Stage 0 starts from the unity term, each later stage adds its own product
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            stage_q <= '0;
        end else begin
            stage_q[0] <= unity_term + prod[0];
            for (int s = 1; s < NTAPS; s++) begin
                stage_q[s] <= stage_q[s-1] + prod[s];
            end
        end
    end

    // Extra delay so a shorter chain lines up with a longer one
    if (ALIGN > 0) begin : g_align
        pole_fir_pkg::acc_t [ALIGN-1:0] align_q;

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                align_q <= '0;
            end else begin
                align_q[0] <= stage_q[NTAPS-1];
                for (int a = 1; a < ALIGN; a++) begin
                    align_q[a] <= align_q[a-1];
                end
            end
        end

        assign chain_sum = align_q[ALIGN-1];
    end else begin : g_no_align
        assign chain_sum = stage_q[NTAPS-1];
    end

    // Previous sum, shifted down by the fraction bits and cut to A width
    assign prev_arg  = prev_q[`PF_COEFF_FRAC +: `PF_ARG_W];
    assign tail_prod = coeff_i[NTAPS] * prev_arg;

    // Tail stage: current sum plus tail coefficient times the previous sum
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            prev_q <= '0;
            filt_q <= '0;
        end else begin
            prev_q <= chain_sum;
            filt_q <= chain_sum + tail_prod;
        end
    end

    // sum_o is the chain sum one cycle late, in step with the previous-sum term
    assign sum_o  = prev_q;
    assign filt_o = filt_q;

endmodule

/* design/pole_fir_pkg.sv */
`include "pole_fir_cfg.svh"

package pole_fir_pkg;

    // One signed input sample
    typedef logic signed [`PF_SAMP_W-1:0] sample_t;

    // One signed coefficient
    typedef logic signed [`PF_COEFF_W-1:0] coeff_t;

    // Running sum of a chain, also the output format
    typedef logic signed [`PF_ACC_W-1:0] acc_t;

    // Previous sum shifted down and cut to multiplier width
    typedef logic signed [`PF_ARG_W-1:0] arg_t;

    // All samples of one clock, sample 0 in the low bits
    typedef sample_t [`PF_NSAMP-1:0] sample_vec_t;

    // Which coefficient bank a write goes to
    typedef logic [1:0] coeff_sel_t;

    // Decoded and registered coefficient control
    typedef struct packed {
        logic   f_wr;
        logic   g_wr;
        logic   fx_wr;
        logic   gx_wr;
        logic   update;
        coeff_t data;
    } coeff_wr_t;

endpackage

/* design/sample_skew.sv */
`timescale 1ns/1ns
`include "pole_fir_cfg.svh"

module sample_skew (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  pole_fir_pkg::sample_vec_t                dat_i,
    output pole_fir_pkg::sample_t [`PF_F_TAPS-1:0]   f_tap_o,
    output pole_fir_pkg::sample_t [`PF_G_TAPS-1:0]   g_tap_o
);

    // Head of the g chain multiplies x[0] straight off the input
    assign g_tap_o[0] = dat_i[0];

    // One line per sample x[j+2], j+1 registers long
    // f tap j wants delay j, g tap j+1 wants delay j+1, so the g tap
    // is just one register further down the same line
    for (genvar j = 0; j < `PF_F_TAPS; j++) begin : g_line
        pole_fir_pkg::sample_t [j:0] dly_q;

        always_ff @(posedge clk or negedge rst_n_i) begin
            if (!rst_n_i) begin
                dly_q <= '0;
            end else begin
                dly_q[0] <= dat_i[j+2];
                for (int d = 1; d <= j; d++) begin
                    dly_q[d] <= dly_q[d-1];
                end
            end
        end

        // First f tap has no delay at all
        if (j == 0) begin : g_direct
            assign f_tap_o[j] = dat_i[j+2];
        end else begin : g_delayed
            assign f_tap_o[j] = dly_q[j-1];
        end

        assign g_tap_o[j+1] = dly_q[j];
    end

endmodule

/* dv/tb_pole_fir_model.svh */
`ifndef TB_POLE_FIR_MODEL_SVH
`define TB_POLE_FIR_MODEL_SVH

`include "pole_fir_cfg.svh"

// Arithmetic shift down by the fraction bits, then keep 30 bits as signed
function automatic longint trunc_sum(input pole_fir_pkg::acc_t v);
    longint w;
    w = longint'(v);
    w = w >>> `PF_COEFF_FRAC;
    return longint'(pole_fir_pkg::arg_t'(w));
endfunction

// f[n]: unity x[0], then cf[j] against x[j+2]
function automatic pole_fir_pkg::acc_t f_chain_sum(
    input pole_fir_pkg::sample_vec_t          x,
    input pole_fir_pkg::coeff_t [`PF_F_TAPS:0] cf
);
    longint acc;
    acc = longint'(x[0]) <<< `PF_COEFF_FRAC;
    for (int j = 0; j < `PF_F_TAPS; j++) begin
        acc += longint'(cf[j]) * longint'(x[j+2]);
    end
    return pole_fir_pkg::acc_t'(acc);
endfunction

// g[n]: unity x[1], cg[0] against x[0], then cg[j] against x[j+1]
function automatic pole_fir_pkg::acc_t g_chain_sum(
    input pole_fir_pkg::sample_vec_t          x,
    input pole_fir_pkg::coeff_t [`PF_G_TAPS:0] cg
);
    longint acc;
    acc = longint'(x[1]) <<< `PF_COEFF_FRAC;
    acc += longint'(cg[0]) * longint'(x[0]);
    for (int j = 1; j < `PF_G_TAPS; j++) begin
        acc += longint'(cg[j]) * longint'(x[j+1]);
    end
    return pole_fir_pkg::acc_t'(acc);
endfunction

// Both outputs for vector cur, with prev as the vector one clock earlier
function automatic void model_outputs(
    input  pole_fir_pkg::sample_vec_t           cur,
    input  pole_fir_pkg::sample_vec_t           prev,
    input  pole_fir_pkg::coeff_t [`PF_F_TAPS:0] cf,
    input  pole_fir_pkg::coeff_t [`PF_G_TAPS:0] cg,
    input  pole_fir_pkg::coeff_t                kf,
    input  pole_fir_pkg::coeff_t                kg,
    output pole_fir_pkg::acc_t                  y0,
    output pole_fir_pkg::acc_t                  y1
);
    pole_fir_pkg::acc_t f_prev;
    pole_fir_pkg::acc_t g_prev;
    longint big_f;
    longint big_g;
    f_prev = f_chain_sum(prev, cf);
    g_prev = g_chain_sum(prev, cg);
    // Tail terms use the chain's own previous sum
    big_f = longint'(f_chain_sum(cur, cf)) + longint'(cf[`PF_F_TAPS]) * trunc_sum(f_prev);
    big_g = longint'(g_chain_sum(cur, cg)) + longint'(cg[`PF_G_TAPS]) * trunc_sum(g_prev);
    // Cross terms use the other chain, everything wraps at 48 bits
    y0 = pole_fir_pkg::acc_t'(big_f + longint'(kf) * trunc_sum(g_prev));
    y1 = pole_fir_pkg::acc_t'(big_g + longint'(kg) * trunc_sum(f_prev));
endfunction

`endif

/* dv/tb_biquad8_pole_fir.sv */
`timescale 1ns/1ns
`include "pole_fir_cfg.svh"

module tb_biquad8_pole_fir;

    // Rising edges between driving a vector and checking its outputs
    localparam int LATENCY = 9;
    // Idle cycles after an update before checks resume
    localparam int SETTLE = 12;
    localparam int SEED = 32'h4b98;
    localparam int N_BASIC = 30;
    localparam int N_SHORT = 40;
    localparam int N_HOLD = 20;
    localparam int N_LONG = 200;
    localparam int F_WORDS = `PF_F_TAPS + 1;
    localparam int G_WORDS = `PF_G_TAPS + 1;
    // Cycles spent by all tests together
    localparam int TEST_CYCLES = N_BASIC
        + (F_WORDS + 1 + SETTLE + N_SHORT)
        + (G_WORDS + 1 + SETTLE + N_SHORT)
        + (F_WORDS + G_WORDS + N_HOLD + 1 + SETTLE + N_SHORT)
        + (F_WORDS + G_WORDS + 2 + 1 + SETTLE + N_LONG);
    localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 50;

    logic                       clk;
    logic                       rst_n_i;
    pole_fir_pkg::sample_vec_t  dat_i;
    pole_fir_pkg::coeff_sel_t   coeff_adr_i;
    logic                       coeff_wr_i;
    logic                       coeff_update_i;
    pole_fir_pkg::coeff_t       coeff_dat_i;
    pole_fir_pkg::acc_t         y0_o;
    pole_fir_pkg::acc_t         y1_o;

    // Every driven vector in drive order
    pole_fir_pkg::sample_vec_t hist[$];

    // Expected shadow and active banks
    pole_fir_pkg::coeff_t [`PF_F_TAPS:0] f_shadow;
    pole_fir_pkg::coeff_t [`PF_F_TAPS:0] f_active;
    pole_fir_pkg::coeff_t [`PF_G_TAPS:0] g_shadow;
    pole_fir_pkg::coeff_t [`PF_G_TAPS:0] g_active;
    pole_fir_pkg::coeff_t fx_shadow;
    pole_fir_pkg::coeff_t fx_active;
    pole_fir_pkg::coeff_t gx_shadow;
    pole_fir_pkg::coeff_t gx_active;

    `include "tb_pole_fir_model.svh"

    biquad8_pole_fir uut (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dat_i          (dat_i),
        .coeff_adr_i    (coeff_adr_i),
        .coeff_wr_i     (coeff_wr_i),
        .coeff_update_i (coeff_update_i),
        .coeff_dat_i    (coeff_dat_i),
        .y0_o           (y0_o),
        .y1_o           (y1_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("error: simulation timed out after %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    task automatic check_val(
        input string              name,
        input pole_fir_pkg::acc_t exp_v,
        input pole_fir_pkg::acc_t act_v
    );
        if (act_v !== exp_v) begin
            $display("error: time %0t %s expected %0d actual %0d", $time, name, exp_v, act_v);
            $display("TB FAILED");
            $fatal(1, "output mismatch");
        end
    endtask

    // Before the first drive the pipeline holds zeros
    function automatic pole_fir_pkg::sample_vec_t vec_at(input int idx);
        if (idx < 0) begin
            return '0;
        end
        return hist[idx];
    endfunction

    function automatic pole_fir_pkg::sample_vec_t rand_vec(input bit extremes);
        pole_fir_pkg::sample_vec_t v;
        int pick;
        for (int k = 0; k < `PF_NSAMP; k++) begin
            v[k] = pole_fir_pkg::sample_t'($urandom);
            pick = $urandom_range(7);
            // Full-scale samples now and then
            if (extremes && pick == 0) begin
                v[k] = {1'b0, {(`PF_SAMP_W-1){1'b1}}};
            end else if (extremes && pick == 1) begin
                v[k] = {1'b1, {(`PF_SAMP_W-1){1'b0}}};
            end
        end
        return v;
    endfunction

    // Outputs are checked on the falling edge before strobes clear and the next vector goes out
    task automatic step(input pole_fir_pkg::sample_vec_t vec, input bit chk);
        pole_fir_pkg::acc_t exp_y0;
        pole_fir_pkg::acc_t exp_y1;
        int idx;
        @(negedge clk);
        if (chk) begin
            idx = hist.size() - LATENCY;
            model_outputs(vec_at(idx), vec_at(idx - 1), f_active, g_active,
                          fx_active, gx_active, exp_y0, exp_y1);
            check_val("y0_o", exp_y0, y0_o);
            check_val("y1_o", exp_y1, y1_o);
        end
        coeff_wr_i     = 1'b0;
        coeff_update_i = 1'b0;
        dat_i          = vec;
        hist.push_back(vec);
    endtask

    task automatic stream(input int n, input bit extremes);
        repeat (n) step(rand_vec(extremes), 1'b1);
    endtask

    // Newest word lands in position 0 and the rest move toward the tail
    task automatic write_coeff(
        input pole_fir_pkg::coeff_sel_t sel,
        input pole_fir_pkg::coeff_t     val
    );
        step(rand_vec(1'b0), 1'b1);
        coeff_adr_i = sel;
        coeff_dat_i = val;
        coeff_wr_i  = 1'b1;
        case (sel)
            `PF_SEL_F:  f_shadow = {f_shadow[`PF_F_TAPS-1:0], val};
            `PF_SEL_G:  g_shadow = {g_shadow[`PF_G_TAPS-1:0], val};
            `PF_SEL_FX: fx_shadow = val;
            default:    gx_shadow = val;
        endcase
    endtask

    task automatic load_bank(input pole_fir_pkg::coeff_sel_t sel, input int words);
        repeat (words) write_coeff(sel, pole_fir_pkg::coeff_t'($urandom));
    endtask

    // Shadows go active and the pipeline drains unchecked
    task automatic update_coeff();
        step(rand_vec(1'b0), 1'b1);
        coeff_update_i = 1'b1;
        f_active  = f_shadow;
        g_active  = g_shadow;
        fx_active = fx_shadow;
        gx_active = gx_shadow;
        repeat (SETTLE) step(rand_vec(1'b0), 1'b0);
    endtask

    // Zero coefficients leave zeros first and then the unity terms alone
    task automatic unity_passthrough();
        stream(N_BASIC, 1'b0);
    endtask

    task automatic f_bank_update();
        load_bank(`PF_SEL_F, F_WORDS);
        update_coeff();
        stream(N_SHORT, 1'b0);
    endtask

    task automatic g_bank_update();
        load_bank(`PF_SEL_G, G_WORDS);
        update_coeff();
        stream(N_SHORT, 1'b0);
    endtask

    // Writes alone keep the old active set
    task automatic shadow_hold();
        load_bank(`PF_SEL_F, F_WORDS);
        load_bank(`PF_SEL_G, G_WORDS);
        stream(N_HOLD, 1'b0);
        update_coeff();
        stream(N_SHORT, 1'b0);
    endtask

    task automatic all_banks_random();
        load_bank(`PF_SEL_F, F_WORDS);
        load_bank(`PF_SEL_G, G_WORDS);
        load_bank(`PF_SEL_FX, 1);
        load_bank(`PF_SEL_GX, 1);
        update_coeff();
        stream(N_LONG, 1'b1);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n_i        = 1'b0;
        dat_i          = '0;
        coeff_adr_i    = '0;
        coeff_wr_i     = 1'b0;
        coeff_update_i = 1'b0;
        coeff_dat_i    = '0;
        f_shadow       = '0;
        f_active       = '0;
        g_shadow       = '0;
        g_active       = '0;
        fx_shadow      = '0;
        fx_active      = '0;
        gx_shadow      = '0;
        gx_active      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        unity_passthrough();
        f_bank_update();
        g_bank_update();
        shadow_hold();
        all_banks_random();
        $display("TB PASSED");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+design
+incdir+dv
design/pole_fir_pkg.sv
design/pole_coeff_regs.sv
design/sample_skew.sv
design/pole_fir_chain.sv
design/pole_cross_link.sv
design/biquad8_pole_fir.sv
dv/tb_biquad8_pole_fir.sv
